// ==== Makefile ====
TOP := impossible_game_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): impossible_game_top.f source/*.sv verif/*.sv
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f impossible_game_top.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | tee sim.log
	@if grep -q "Simulation finished: FAIL" sim.log; then echo "Run failed"; exit 1; fi
	@grep -q "Simulation finished: PASS" sim.log || (echo "Run did not complete"; exit 1)

lint:
	verilator --lint-only --timing --assert -Wall --top-module $(TOP) -f impossible_game_top.f

clean:
	rm -rf obj_dir sim.log

// ==== impossible_game_top.f ====
source/game_pkg.sv
source/frame_timer.sv
source/scene_table.sv
source/shape_rasterizer.sv
source/frame_sequencer.sv
source/attempts_display.sv
source/impossible_game_top.sv
verif/impossible_game_assert.sv
verif/impossible_game_tb.sv

// ==== source/attempts_display.sv ====
`timescale 1ns/1ps

module attempts_display (
    input  logic       clock,
    input  logic       rst,
    input  logic       start_switch,
    output logic [6:0] hex0,
    output logic [6:0] hex1
);
    logic       sw_meta;
    logic       sw_sync;
    logic       sw_prev;
    logic [7:0] attempts;

    // Active-low segments, bit 0 is segment a
    function automatic logic [6:0] hex_segments(input logic [3:0] digit);
        case (digit)
            4'h0: return 7'b1000000;
            4'h1: return 7'b1111001;
            4'h2: return 7'b0100100;
            4'h3: return 7'b0110000;
            4'h4: return 7'b0011001;
            4'h5: return 7'b0010010;
            4'h6: return 7'b0000010;
            4'h7: return 7'b1111000;
            4'h8: return 7'b0000000;
            4'h9: return 7'b0010000;
            4'ha: return 7'b0001000;
            4'hb: return 7'b0000011;
            4'hc: return 7'b1000110;
            4'hd: return 7'b0100001;
            4'he: return 7'b0000110;
            default: return 7'b0001110;
        endcase
    endfunction

    always_ff @(posedge clock) begin
        if (rst) begin
            sw_meta  <= 1'b0;
            sw_sync  <= 1'b0;
            sw_prev  <= 1'b0;
            attempts <= '0;
        end else begin
            sw_meta  <= start_switch;
            sw_sync  <= sw_meta;
            sw_prev  <= sw_sync;
            if (sw_sync && !sw_prev) attempts <= attempts + 1'b1;  // Wraps at 256
        end
    end

    assign hex0 = hex_segments(attempts[3:0]);
    assign hex1 = hex_segments(attempts[7:4]);
endmodule

// ==== source/frame_sequencer.sv ====
`timescale 1ns/1ps

module frame_sequencer (
    input  logic                 clock,
    input  logic                 rst,
    input  logic                 frame_tick,
    input  logic                 start_switch,
    output game_pkg::scene_idx_t scene_sel,
    input  logic                 obstacle,
    output logic                 shape_start,
    input  logic                 pix_valid,
    input  game_pkg::coord_t     pix_x,
    input  game_pkg::coord_t     pix_y,
    input  game_pkg::colour_t    pix_colour,
    input  logic                 shape_done,
    output logic                 plot,
    output game_pkg::coord_t     x,
    output game_pkg::coord_t     y,
    output game_pkg::colour_t    colour,
    output logic                 frame_busy
);
    typedef enum logic [1:0] {
        st_idle,
        st_clear,
        st_shape_start,
        st_shape_wait
    } state_t;

    state_t           state;
    logic             run_q;  // Switch as seen at frame start
    game_pkg::coord_t clear_x;
    game_pkg::coord_t clear_y;
    logic             clear_row_end;
    logic             clear_last;
    logic             pass_end;

    assign clear_row_end = clear_x == game_pkg::coord_t'(game_pkg::screen_w - 1);
    assign clear_last    = clear_row_end
                           && clear_y == game_pkg::coord_t'(game_pkg::screen_h - 1);

    // Past the list, or obstacles not wanted this frame
    assign pass_end = scene_sel >= game_pkg::scene_idx_t'(game_pkg::scene_len)
                      || (obstacle && !run_q);

    assign shape_start = state == st_shape_start && !pass_end;
    assign frame_busy  = state != st_idle;

    always_ff @(posedge clock) begin
        if (rst) begin
            state     <= st_idle;
            run_q     <= 1'b0;
            scene_sel <= '0;
            clear_x   <= '0;
            clear_y   <= '0;
        end else begin
            case (state)
                st_idle: begin
                    // Ticks during a frame are simply lost
                    if (frame_tick) begin
                        state   <= st_clear;
                        run_q   <= start_switch;
                        clear_x <= '0;
                        clear_y <= '0;
                    end
                end
                st_clear: begin
                    if (clear_row_end) begin
                        clear_x <= '0;
                        clear_y <= clear_y + 1'b1;
                        if (clear_last) begin
                            state     <= st_shape_start;
                            scene_sel <= '0;
                        end
                    end else begin
                        clear_x <= clear_x + 1'b1;
                    end
                end
                st_shape_start: state <= pass_end ? st_idle : st_shape_wait;
                st_shape_wait: begin
                    if (shape_done) begin
                        scene_sel <= scene_sel + 1'b1;
                        state     <= st_shape_start;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Clear pass and rasterizer never overlap
    always_ff @(posedge clock) begin
        if (rst) plot <= 1'b0;
        else     plot <= state == st_clear || pix_valid;
    end

    always_ff @(posedge clock) begin
        if (state == st_clear) begin
            x      <= clear_x;
            y      <= clear_y;
            colour <= game_pkg::colour_black;
        end else begin
            x      <= pix_x;
            y      <= pix_y;
            colour <= pix_colour;
        end
    end
endmodule

// ==== source/frame_timer.sv ====
`timescale 1ns/1ps

module frame_timer #(
    parameter int frame_cycles = game_pkg::frame_cycles_default
) (
    input  logic clock,
    input  logic rst,
    output logic frame_tick
);
    logic [$clog2(frame_cycles + 1)-1:0] count;

    // Down counter, one tick per wrap
    always_ff @(posedge clock) begin
        if (rst) begin
            count      <= ($clog2(frame_cycles + 1))'(frame_cycles - 1);
            frame_tick <= 1'b0;
        end else if (count == '0) begin
            count      <= ($clog2(frame_cycles + 1))'(frame_cycles - 1);
            frame_tick <= 1'b1;
        end else begin
            count      <= count - 1'b1;
            frame_tick <= 1'b0;
        end
    end
endmodule

// ==== source/game_pkg.sv ====
package game_pkg;

    // Screen size in pixels
    localparam int screen_w = 160;
    localparam int screen_h = 120;

    typedef logic [7:0] coord_t;   // Fits 0..159
    typedef logic [2:0] colour_t;  // One bit per RGB channel

    localparam colour_t colour_black  = 3'b000;
    localparam colour_t colour_red    = 3'b100;
    localparam colour_t colour_yellow = 3'b110;
    localparam colour_t colour_white  = 3'b111;

    localparam int shape_size = 10;  // Edge of every shape

    typedef enum logic {
        kind_square,  // Full rows
        kind_spike    // Narrows towards the top
    } shape_kind_t;

    // Column offsets per row, row 0 is the top row
    localparam logic [3:0] spike_span_start [shape_size] =
        '{4'd4, 4'd4, 4'd3, 4'd3, 4'd2, 4'd2, 4'd1, 4'd1, 4'd0, 4'd0};
    localparam logic [3:0] spike_span_end [shape_size] =
        '{4'd5, 4'd5, 4'd6, 4'd6, 4'd7, 4'd7, 4'd8, 4'd8, 4'd9, 4'd9};

    localparam int scene_len = 6;
    typedef logic [2:0] scene_idx_t;

    // Bottom-left corner of the player
    localparam coord_t player_x = 8'd59;
    localparam coord_t player_y = 8'd89;

    // Entry 0 is the player, then two blocks and three spikes
    localparam coord_t scene_x [scene_len] =
        '{player_x, 8'd69, 8'd100, 8'd120, 8'd135, 8'd148};
    localparam coord_t scene_y [scene_len] =
        '{player_y, 8'd89, 8'd59, 8'd89, 8'd59, 8'd89};
    localparam shape_kind_t scene_kind [scene_len] =
        '{kind_square, kind_square, kind_square, kind_spike, kind_spike, kind_spike};

    localparam int frame_cycles_default = 833333;  // 60 fps at 50 MHz

endpackage

// ==== source/impossible_game_top.sv ====
`timescale 1ns/1ps

module impossible_game_top #(
    parameter int frame_cycles = game_pkg::frame_cycles_default
) (
    input  logic              clock,
    input  logic              rst,
    input  logic              start_switch,
    output logic              plot,
    output game_pkg::coord_t  x,
    output game_pkg::coord_t  y,
    output game_pkg::colour_t colour,
    output logic              frame_busy,
    output logic [6:0]        hex0,
    output logic [6:0]        hex1
);
    logic                  frame_tick;
    game_pkg::scene_idx_t  scene_sel;
    game_pkg::coord_t      shape_x;
    game_pkg::coord_t      shape_y;
    game_pkg::shape_kind_t shape_kind;
    game_pkg::colour_t     shape_colour;
    logic                  obstacle;
    logic                  shape_start;
    logic                  pix_valid;
    game_pkg::coord_t      pix_x;
    game_pkg::coord_t      pix_y;
    game_pkg::colour_t     pix_colour;
    logic                  shape_done;

    frame_timer #(.frame_cycles(frame_cycles)) u_frame_timer (
        .clock(clock), .rst(rst), .frame_tick(frame_tick)
    );

    // Scene lookup steered by the sequencer
    scene_table u_scene_table (
        .scene_sel(scene_sel), .shape_x(shape_x), .shape_y(shape_y),
        .shape_kind(shape_kind), .shape_colour(shape_colour), .obstacle(obstacle)
    );

    shape_rasterizer u_shape_rasterizer (
        .clock(clock), .rst(rst), .shape_start(shape_start),
        .shape_x(shape_x), .shape_y(shape_y), .shape_kind(shape_kind),
        .shape_colour(shape_colour), .pix_valid(pix_valid), .pix_x(pix_x),
        .pix_y(pix_y), .pix_colour(pix_colour), .shape_done(shape_done)
    );

    frame_sequencer u_frame_sequencer (
        .clock(clock), .rst(rst), .frame_tick(frame_tick),
        .start_switch(start_switch), .scene_sel(scene_sel), .obstacle(obstacle),
        .shape_start(shape_start), .pix_valid(pix_valid), .pix_x(pix_x),
        .pix_y(pix_y), .pix_colour(pix_colour), .shape_done(shape_done),
        .plot(plot), .x(x), .y(y), .colour(colour), .frame_busy(frame_busy)
    );

    attempts_display u_attempts_display (
        .clock(clock), .rst(rst), .start_switch(start_switch),
        .hex0(hex0), .hex1(hex1)
    );
endmodule

// ==== source/scene_table.sv ====
`timescale 1ns/1ps

module scene_table (
    input  game_pkg::scene_idx_t  scene_sel,
    output game_pkg::coord_t      shape_x,
    output game_pkg::coord_t      shape_y,
    output game_pkg::shape_kind_t shape_kind,
    output game_pkg::colour_t     shape_colour,
    output logic                  obstacle
);
    logic in_range;

    assign in_range = scene_sel < game_pkg::scene_idx_t'(game_pkg::scene_len);

    always_comb begin
        shape_x      = '0;
        shape_y      = '0;
        shape_kind   = game_pkg::kind_square;
        shape_colour = game_pkg::colour_black;
        obstacle     = 1'b0;
        if (in_range) begin
            shape_x    = game_pkg::scene_x[scene_sel];
            shape_y    = game_pkg::scene_y[scene_sel];
            shape_kind = game_pkg::scene_kind[scene_sel];
            obstacle   = scene_sel != '0;  // Everything but the player
            // Colour follows from kind and slot
            if (shape_kind == game_pkg::kind_spike) begin
                shape_colour = game_pkg::colour_white;
            end else if (obstacle) begin
                shape_colour = game_pkg::colour_yellow;
            end else begin
                shape_colour = game_pkg::colour_red;
            end
        end
    end
endmodule

// ==== source/shape_rasterizer.sv ====
`timescale 1ns/1ps

module shape_rasterizer (
    input  logic                  clock,
    input  logic                  rst,
    input  logic                  shape_start,
    input  game_pkg::coord_t      shape_x,
    input  game_pkg::coord_t      shape_y,
    input  game_pkg::shape_kind_t shape_kind,
    input  game_pkg::colour_t     shape_colour,
    output logic                  pix_valid,
    output game_pkg::coord_t      pix_x,
    output game_pkg::coord_t      pix_y,
    output game_pkg::colour_t     pix_colour,
    output logic                  shape_done
);
    game_pkg::coord_t      corner_x;
    game_pkg::coord_t      corner_y;
    game_pkg::shape_kind_t kind_q;
    game_pkg::colour_t     colour_q;
    logic                  scan_active;
    logic [3:0]            scan_row;
    logic [3:0]            scan_col;
    logic                  scan_last;
    logic                  s1_valid;
    logic                  s1_last;
    logic [3:0]            s1_row;
    logic [3:0]            s1_col;
    logic                  out_last;
    logic [3:0]            span_start;
    logic [3:0]            span_end;
    logic                  in_span;

    assign scan_last = scan_active && scan_row == 4'(game_pkg::shape_size - 1)
                       && scan_col == 4'(game_pkg::shape_size - 1);

    always_ff @(posedge clock) begin
        if (shape_start) begin
            corner_x <= shape_x;
            corner_y <= shape_y;
            kind_q   <= shape_kind;
            colour_q <= shape_colour;
        end
    end

    // Scan stage, top row first, left to right
    always_ff @(posedge clock) begin
        if (rst) begin
            scan_active <= 1'b0;
            scan_row    <= '0;
            scan_col    <= '0;
        end else if (shape_start) begin
            scan_active <= 1'b1;
            scan_row    <= '0;
            scan_col    <= '0;
        end else if (scan_active) begin
            if (scan_col == 4'(game_pkg::shape_size - 1)) begin
                scan_col <= '0;
                scan_row <= scan_row + 1'b1;
                if (scan_last) scan_active <= 1'b0;
            end else begin
                scan_col <= scan_col + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            s1_valid <= 1'b0;
            s1_last  <= 1'b0;
        end else begin
            s1_valid <= scan_active;
            s1_last  <= scan_last;
        end
    end

    always_ff @(posedge clock) begin
        s1_row <= scan_row;
        s1_col <= scan_col;
    end

    // Span of the row being tested
    always_comb begin
        if (kind_q == game_pkg::kind_spike) begin
            span_start = game_pkg::spike_span_start[s1_row];
            span_end   = game_pkg::spike_span_end[s1_row];
        end else begin
            span_start = 4'd0;
            span_end   = 4'(game_pkg::shape_size - 1);
        end
    end

    assign in_span = s1_col >= span_start && s1_col <= span_end;

    always_ff @(posedge clock) begin
        if (rst) begin
            pix_valid  <= 1'b0;
            out_last   <= 1'b0;
            shape_done <= 1'b0;
        end else begin
            pix_valid  <= s1_valid && in_span;
            out_last   <= s1_last;
            shape_done <= out_last;  // Last position has gone
        end
    end

    // Corner is bottom-left, so rows count up from corner_y - 9
    always_ff @(posedge clock) begin
        pix_x      <= corner_x + {4'd0, s1_col};
        pix_y      <= corner_y - 8'(game_pkg::shape_size - 1) + {4'd0, s1_row};
        pix_colour <= colour_q;
    end
endmodule

// ==== verif/impossible_game_assert.sv ====
`timescale 1ns/1ps

module game_checks (
    input logic       clock,
    input logic       rst,
    input logic       start_switch,
    input logic       plot,
    input logic [7:0] x,
    input logic [7:0] y,
    input logic [2:0] colour,
    input logic       frame_busy,
    input logic [6:0] hex0,
    input logic [6:0] hex1
);
    // Active-low segment patterns for 0..F with bit 0 as segment a
    localparam logic [6:0] seg_table [16] = '{
        7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
        7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e};

    int         err_reset = 0;
    int         err_range = 0;
    int         err_place = 0;
    int         err_run = 0;
    int         err_hex = 0;
    int         fail_count;
    logic       busy_q;
    logic       switch_q;
    logic       run_frame;  // Switch as the frame start saw it
    logic       rise_seen;  // Switch has gone high since reset
    logic [4:0] lo_digit;
    logic [4:0] hi_digit;
    logic [7:0] shown;

    // Box of 10x10 with its corner at bottom left
    function automatic logic in_box(input int px, input int py, input int cx, input int cy);
        return px >= cx && px <= cx + 9 && py >= cy - 9 && py <= cy;
    endfunction

    // Span widens by one column each side every two rows
    function automatic logic in_spike(input int px, input int py, input int cx, input int cy);
        int row;
        int off;
        row = py - (cy - 9);
        off = px - cx;
        return in_box(px, py, cx, cy) && off >= 4 - row / 2 && off <= 5 + row / 2;
    endfunction

    function automatic logic placed_ok(input int px, input int py, input logic [2:0] c);
        case (c)
            game_pkg::colour_black:  return 1'b1;
            game_pkg::colour_red:    return in_box(px, py, 59, 89);
            game_pkg::colour_yellow: return in_box(px, py, 69, 89) || in_box(px, py, 100, 59);
            game_pkg::colour_white:
                return in_spike(px, py, 120, 89) || in_spike(px, py, 135, 59)
                       || in_spike(px, py, 148, 89);
            default: return 1'b0;
        endcase
    endfunction

    // Top bit flags a known pattern
    function automatic logic [4:0] seg_digit(input logic [6:0] seg);
        for (int i = 0; i < 16; i++) begin
            if (seg == seg_table[i]) return {1'b1, 4'(i)};
        end
        return 5'd0;
    endfunction

    assign fail_count = err_reset + err_range + err_place + err_run + err_hex;
    assign lo_digit   = seg_digit(hex0);
    assign hi_digit   = seg_digit(hex1);
    assign shown      = {hi_digit[3:0], lo_digit[3:0]};

    always_ff @(posedge clock) begin
        if (rst) begin
            busy_q    <= 1'b0;
            switch_q  <= 1'b0;
            run_frame <= 1'b0;
            rise_seen <= 1'b0;
        end else begin
            busy_q   <= frame_busy;
            switch_q <= start_switch;
            if (frame_busy && !busy_q) run_frame <= switch_q;  // Value at the tick
            if (start_switch && !switch_q) rise_seen <= 1'b1;
        end
    end

    a_reset: assert property (@(posedge clock) $fell(rst) |-> !plot && !frame_busy)
        else begin
            err_reset++;
            $error("** Error at %0t: plot or frame_busy high after reset", $time);
        end

    a_zero: assert property (@(posedge clock) disable iff (rst)
        !rise_seen |-> hex0 == seg_table[0] && hex1 == seg_table[0])
        else begin
            err_reset++;
            $error("** Error at %0t: display not zero before any switch rise", $time);
        end

    a_range: assert property (@(posedge clock) disable iff (rst)
        plot |-> x < 8'd160 && y < 8'd120 && frame_busy)
        else begin
            err_range++;
            $error("** Error at %0t: plot at (%0d,%0d) off screen or outside frame", $time, x, y);
        end

    a_place: assert property (@(posedge clock) disable iff (rst)
        plot |-> placed_ok(int'(x), int'(y), colour))
        else begin
            err_place++;
            $error("** Error at %0t: colour %0d plotted at (%0d,%0d)", $time, colour, x, y);
        end

    a_run: assert property (@(posedge clock) disable iff (rst)
        plot && !run_frame |-> colour != game_pkg::colour_yellow
                               && colour != game_pkg::colour_white)
        else begin
            err_run++;
            $error("** Error at %0t: obstacle drawn while switch was low", $time);
        end

    a_hex: assert property (@(posedge clock) disable iff (rst)
        $changed(hex0) || $changed(hex1) |->
            lo_digit[4] && hi_digit[4] && shown == 8'($past(shown) + 8'd1))
        else begin
            err_hex++;
            $error("** Error at %0t: display moved to %h, not one more", $time, shown);
        end
endmodule

// ==== verif/impossible_game_tb.sv ====
`timescale 1ns/1ps

module impossible_game_tb;
    localparam int frame_len      = 25000;
    localparam int timeout_cycles = 13 * frame_len;  // 12 frames plus the wait for the first tick

    logic              clock = 1'b0;
    logic              rst = 1'b1;
    logic              start_switch = 1'b0;
    logic              plot;
    game_pkg::coord_t  x;
    game_pkg::coord_t  y;
    game_pkg::colour_t colour;
    logic              frame_busy;
    logic [6:0]        hex0;
    logic [6:0]        hex1;
    logic [31:0]       lfsr_state = 32'h9e6380c2;
    logic              toggling = 1'b0;
    int                cycle_count = 0;
    int                plot_count = 0;
    int                plots_before = 0;
    int                errors_before = 0;
    int                phases_passed = 0;
    int                phases_failed = 0;

    impossible_game_top #(.frame_cycles(frame_len)) DUT (
        .clock(clock), .rst(rst), .start_switch(start_switch), .plot(plot),
        .x(x), .y(y), .colour(colour), .frame_busy(frame_busy),
        .hex0(hex0), .hex1(hex1)
    );

    bind impossible_game_top game_checks u_checks (
        .clock(clock), .rst(rst), .start_switch(start_switch), .plot(plot),
        .x(x), .y(y), .colour(colour), .frame_busy(frame_busy),
        .hex0(hex0), .hex1(hex1)
    );

    always #20 clock = ~clock;

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (plot) plot_count <= plot_count + 1;
        if (cycle_count == timeout_cycles) begin
            $display("Simulation timed out after %0d cycles", cycle_count);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // Taps 32, 22, 2, 1
    function automatic logic lfsr_bit();
        lfsr_state = {lfsr_state[30:0],
                      lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
        return lfsr_state[0];
    endfunction

    function automatic int random_bits(input int n);
        int value;
        value = 0;
        for (int i = 0; i < n; i++) begin
            value = (value << 1) | int'(lfsr_bit());
        end
        return value;
    endfunction

    task automatic step_cycles(input int n);
        repeat (n) @(posedge clock);
        #5;  // Drive point after the edge
    endtask

    // Whole frames, so switch changes land between frames
    task automatic run_frames(input int n);
        repeat (n) begin
            while (!frame_busy) step_cycles(1);
            while (frame_busy) step_cycles(1);
        end
    endtask

    task automatic toggle_switch();
        while (toggling) begin
            step_cycles(4 + random_bits(8));
            if (toggling && frame_busy) start_switch = ~start_switch;  // Never near a tick
        end
    endtask

    task automatic report_phase(input string name);
        int errs;
        errs = DUT.u_checks.fail_count - errors_before;
        if (errs == 0) phases_passed++;
        else phases_failed++;
        $display("Phase %s done: %0d plots, %0d assertion errors",
                 name, plot_count - plots_before, errs);
        errors_before = DUT.u_checks.fail_count;
        plots_before  = plot_count;
    endtask

    initial begin
        step_cycles(3);
        rst = 1'b0;
        run_frames(3);
        report_phase("switch low");
        start_switch = 1'b1;
        run_frames(3);
        report_phase("switch high");
        toggling = 1'b1;
        fork
            toggle_switch();
            begin
                run_frames(3);
                toggling = 1'b0;
            end
        join
        report_phase("toggling");
        start_switch = 1'b1;
        run_frames(3);
        report_phase("switch high again");
        $display("Phases passed %0d, failed %0d, assertion errors %0d",
                 phases_passed, phases_failed, DUT.u_checks.fail_count);
        if (phases_failed == 0 && DUT.u_checks.fail_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end
endmodule
